// ==== tex_cache_defines.svh ====
// texture cache parameters
`ifndef TEX_CACHE_DEFINES_SVH
`define TEX_CACHE_DEFINES_SVH

// texel format
`define TEX_COMP_W          8
`define TEX_COMP_NUM        3
`define TEX_DATA_W          (`TEX_COMP_W * `TEX_COMP_NUM)
`define TEX_BORDER_DATA     {`TEX_DATA_W{1'b0}}

// coordinates and block geometry (sizes are log2)
`define TEX_ADDR_X_W        10
`define TEX_ADDR_Y_W        10
`define TEX_BLK_X_SIZE      2
`define TEX_BLK_Y_SIZE      2
`define TEX_WIDE_SIZE       1       // two texels per memory beat
`define TEX_USER_W          4

// cache organisation
`define TEX_TAG_ADDR_W      4
`define TEX_LINE_NUM        (1 << `TEX_TAG_ADDR_W)
`define TEX_BLK_ADDR_X_W    (`TEX_ADDR_X_W - `TEX_BLK_X_SIZE)
`define TEX_BLK_ADDR_Y_W    (`TEX_ADDR_Y_W - `TEX_BLK_Y_SIZE)
`define TEX_IDX_X_W         (`TEX_TAG_ADDR_W / 2)
`define TEX_IDX_Y_W         (`TEX_TAG_ADDR_W - `TEX_IDX_X_W)
`define TEX_TAG_W           (`TEX_BLK_ADDR_X_W - `TEX_IDX_X_W + `TEX_BLK_ADDR_Y_W - `TEX_IDX_Y_W)
`define TEX_OFFSET_W        (`TEX_BLK_X_SIZE + `TEX_BLK_Y_SIZE)
`define TEX_BEAT_W          (`TEX_OFFSET_W - `TEX_WIDE_SIZE)

`endif

// ==== tex_cache_pkg.sv ====
// texture cache types
`include "tex_cache_defines.svh"

package tex_cache_pkg;

	typedef logic [`TEX_DATA_W-1:0] texel_t;

	typedef struct packed {
		logic [`TEX_USER_W-1:0]   user;
		logic [`TEX_ADDR_X_W-1:0] x;
		logic [`TEX_ADDR_Y_W-1:0] y;
	} tex_req_t;

	typedef struct packed {
		logic [`TEX_USER_W-1:0] user;
		texel_t                 data;
	} tex_resp_t;

	typedef struct packed {
		logic [`TEX_BLK_ADDR_X_W-1:0] bx;
		logic [`TEX_BLK_ADDR_Y_W-1:0] by;
	} mem_ar_t;

	typedef struct packed {
		logic                                 last;
		texel_t [(1 << `TEX_WIDE_SIZE)-1:0]   data;   // [0] is the even x texel
	} mem_r_t;

	typedef struct packed {
		logic                  valid;
		logic [`TEX_TAG_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic idle;
		logic stall;
		logic access;
		logic hit;
		logic miss;
	} cache_status_t;

	// ----------------------------------------------------------------------
	// address split
	// ----------------------------------------------------------------------
	function automatic logic [`TEX_TAG_ADDR_W-1:0] line_index(tex_req_t r);
		return {r.y[`TEX_BLK_Y_SIZE +: `TEX_IDX_Y_W], r.x[`TEX_BLK_X_SIZE +: `TEX_IDX_X_W]};
	endfunction

	function automatic logic [`TEX_TAG_W-1:0] line_tag(tex_req_t r);
		return {r.y[`TEX_ADDR_Y_W-1:`TEX_BLK_Y_SIZE+`TEX_IDX_Y_W],
		        r.x[`TEX_ADDR_X_W-1:`TEX_BLK_X_SIZE+`TEX_IDX_X_W]};
	endfunction

	function automatic logic [`TEX_OFFSET_W-1:0] texel_offset(tex_req_t r);
		return {r.y[`TEX_BLK_Y_SIZE-1:0], r.x[`TEX_BLK_X_SIZE-1:0]};
	endfunction

endpackage

// ==== tex_cache_tag.sv ====
// texture cache tag store
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_tag (
	input  logic                       clk,
	input  logic                       arst_n,

	input  logic                       clear_start,
	output logic                       clear_busy,

	input  logic                       lookup_en,
	input  logic [`TEX_TAG_ADDR_W-1:0] lookup_index,
	input  logic [`TEX_TAG_W-1:0]      lookup_tag,
	output logic                       hit,

	input  logic                       update_en,
	input  logic [`TEX_TAG_ADDR_W-1:0] update_index,
	input  logic [`TEX_TAG_W-1:0]      update_tag
);

	logic [`TEX_LINE_NUM-1:0]   valid_bits;
	logic [`TEX_TAG_W-1:0]      tag_mem [`TEX_LINE_NUM];
	logic [`TEX_TAG_ADDR_W-1:0] clr_cnt;
	tex_cache_pkg::tag_entry_t  rd_entry;

	assign rd_entry.valid = valid_bits[lookup_index];
	assign rd_entry.tag   = tag_mem[lookup_index];

	// ----------------------------------------------------------------------
	// valid bits, clear sweep and registered compare
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			clear_busy <= 1'b0;
			clr_cnt    <= '0;
			hit        <= 1'b0;
		end else begin
			if (clear_start) begin
				clear_busy <= 1'b1;
				clr_cnt    <= '0;
			end else if (clear_busy) begin
				valid_bits[clr_cnt] <= 1'b0;     // one line per cycle
				clr_cnt             <= clr_cnt + 1'b1;
				if (clr_cnt == '1)
					clear_busy <= 1'b0;
			end

			if (update_en)
				valid_bits[update_index] <= 1'b1;

			if (lookup_en)
				hit <= rd_entry.valid && (rd_entry.tag == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (update_en)
			tag_mem[update_index] <= update_tag;
	end

	// a fill must never land while the sweep is running
	a_no_update_in_clear: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(update_en && clear_busy)
	);

endmodule

// ==== tex_cache_mem.sv ====
// texture cache block data memory
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_mem (
	input  logic                                             clk,

	input  logic                                             wr_en,
	input  logic [`TEX_TAG_ADDR_W-1:0]                       wr_line,
	input  logic [`TEX_BEAT_W-1:0]                           wr_beat,
	input  tex_cache_pkg::texel_t [(1 << `TEX_WIDE_SIZE)-1:0] wr_data,

	input  logic                                             rd_en,
	input  logic [`TEX_TAG_ADDR_W-1:0]                       rd_line,
	input  logic [`TEX_OFFSET_W-1:0]                         rd_offset,
	output tex_cache_pkg::texel_t                            rd_data
);

	localparam int WORDS = `TEX_LINE_NUM << `TEX_BEAT_W;  // 128 beats

	tex_cache_pkg::texel_t [(1 << `TEX_WIDE_SIZE)-1:0] mem [WORDS];

	logic [`TEX_BEAT_W-1:0]    rd_beat;
	logic [`TEX_WIDE_SIZE-1:0] rd_sel;

	// beat is {row, x[1]}, the x parity picks the half
	assign rd_beat = rd_offset[`TEX_OFFSET_W-1:`TEX_WIDE_SIZE];
	assign rd_sel  = rd_offset[`TEX_WIDE_SIZE-1:0];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_line, wr_beat}] <= wr_data;   // whole beat at once
		if (rd_en)
			rd_data <= mem[{rd_line, rd_beat}][rd_sel];
	end

endmodule

// ==== tex_cache_fill.sv ====
// texture cache miss fill
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_fill (
	input  logic                                             clk,
	input  logic                                             arst_n,

	input  logic                                             miss_start,
	input  tex_cache_pkg::tex_req_t                          miss_req,

	output tex_cache_pkg::mem_ar_t                           m_ar,
	output logic                                             m_arvalid,
	input  logic                                             m_arready,
	input  tex_cache_pkg::mem_r_t                            m_r,
	input  logic                                             m_rvalid,

	output logic                                             wr_en,
	output logic [`TEX_TAG_ADDR_W-1:0]                       wr_line,
	output logic [`TEX_BEAT_W-1:0]                           wr_beat,
	output tex_cache_pkg::texel_t [(1 << `TEX_WIDE_SIZE)-1:0] wr_data,

	output logic                                             update_en,
	output logic [`TEX_TAG_ADDR_W-1:0]                       update_index,
	output logic [`TEX_TAG_W-1:0]                            update_tag,
	output logic                                             fill_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} state_t;

	state_t                     state;
	logic [`TEX_BEAT_W-1:0]     beat;
	logic [`TEX_TAG_ADDR_W-1:0] fill_line;
	logic [`TEX_TAG_W-1:0]      fill_tag;

	// ----------------------------------------------------------------------
	// fsm
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			beat      <= '0;
			update_en <= 1'b0;
		end else begin
			update_en <= 1'b0;
			case (state)
				ST_IDLE: if (miss_start) state <= ST_ADDR;
				ST_ADDR: begin
					beat <= '0;
					if (m_arready)
						state <= ST_DATA;
				end
				ST_DATA: if (m_rvalid) begin
					beat <= beat + 1'b1;
					if (m_r.last) begin
						state     <= ST_IDLE;
						update_en <= 1'b1;   // tag goes valid after the last beat
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// block address and line of the missing request
	always_ff @(posedge clk) begin
		if (miss_start) begin
			m_ar.bx   <= miss_req.x[`TEX_ADDR_X_W-1:`TEX_BLK_X_SIZE];
			m_ar.by   <= miss_req.y[`TEX_ADDR_Y_W-1:`TEX_BLK_Y_SIZE];
			fill_line <= tex_cache_pkg::line_index(miss_req);
			fill_tag  <= tex_cache_pkg::line_tag(miss_req);
		end
	end

	assign m_arvalid    = (state == ST_ADDR);
	assign wr_en        = (state == ST_DATA) && m_rvalid;
	assign wr_line      = fill_line;
	assign wr_beat      = beat;
	assign wr_data      = m_r.data;
	assign update_index = fill_line;
	assign update_tag   = fill_tag;
	assign fill_done    = update_en;

	// memory side must close the block on the eighth beat
	a_last_on_beat7: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == ST_DATA && m_rvalid) |-> (m_r.last == (beat == '1))
	);

endmodule

// ==== tex_cache_basic.sv ====
// basic direct-mapped texture cache
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_basic (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              clear_start,
	output logic                              clear_busy,
	input  logic [`TEX_ADDR_X_W-1:0]          param_width,
	input  logic [`TEX_ADDR_Y_W-1:0]          param_height,
	output tex_cache_pkg::cache_status_t      status,
	input  tex_cache_pkg::tex_req_t           s_ar,
	input  logic                              s_arvalid,
	output logic                              s_arready,
	output tex_cache_pkg::tex_resp_t          s_r,
	output logic                              s_rvalid,
	input  logic                              s_rready,
	output tex_cache_pkg::mem_ar_t            m_ar,
	output logic                              m_arvalid,
	input  logic                              m_arready,
	input  tex_cache_pkg::mem_r_t             m_r,
	input  logic                              m_rvalid
);

	tex_cache_pkg::tex_req_t st1_req;
	logic st1_valid, st1_phase, st1_border, st1_wait, st1_replay;
	logic s_ar_fire, st1_adv, out_ready, lookup_en, miss_start, lk_first;
	logic tag_hit, fill_done;
	logic [`TEX_TAG_ADDR_W-1:0] lookup_index;
	logic [`TEX_TAG_W-1:0]      lookup_tag;

	logic                                             wr_en;
	logic [`TEX_TAG_ADDR_W-1:0]                       wr_line;
	logic [`TEX_BEAT_W-1:0]                           wr_beat;
	tex_cache_pkg::texel_t [(1 << `TEX_WIDE_SIZE)-1:0] wr_data;
	logic                                             update_en;
	logic [`TEX_TAG_ADDR_W-1:0]                       update_index;
	logic [`TEX_TAG_W-1:0]                            update_tag;

	logic                   out_valid, out_border;
	logic [`TEX_USER_W-1:0] out_user;
	tex_cache_pkg::texel_t  mem_rd;

	assign lookup_index = tex_cache_pkg::line_index(st1_req);
	assign lookup_tag   = tex_cache_pkg::line_tag(st1_req);

	// ----------------------------------------------------------------------
	// lookup stage: phase 0 presents the index, phase 1 has the result
	// ----------------------------------------------------------------------
	assign out_ready  = !out_valid || s_rready;
	assign st1_adv    = st1_valid && st1_phase && out_ready
	                    && (st1_border || (tag_hit && !clear_busy));
	assign s_arready  = !clear_busy && (!st1_valid || st1_adv);
	assign s_ar_fire  = s_arvalid && s_arready;
	assign lookup_en  = st1_valid && !st1_phase && !st1_border && !clear_busy;
	assign miss_start = st1_valid && st1_phase && !st1_border && !tag_hit && !st1_wait
	                    && !clear_busy && !clear_start;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st1_valid  <= 1'b0;
			st1_phase  <= 1'b0;
			st1_replay <= 1'b0;
			st1_wait   <= 1'b0;
			lk_first   <= 1'b0;
		end else begin
			lk_first <= lookup_en && !st1_replay;   // count each request once
			if (miss_start)
				st1_wait <= 1'b1;
			else if (fill_done)
				st1_wait <= 1'b0;

			if (s_ar_fire) begin
				st1_valid  <= 1'b1;
				st1_phase  <= 1'b0;
				st1_replay <= 1'b0;
			end else if (st1_adv) begin
				st1_valid <= 1'b0;
			end else if (fill_done) begin
				st1_phase  <= 1'b0;                  // replay after the fill
				st1_replay <= 1'b1;
			end else if (clear_busy) begin
				st1_phase  <= 1'b0;
				st1_replay <= st1_replay || st1_phase;
			end else if (st1_valid && !st1_phase) begin
				st1_phase <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_ar_fire) begin
			st1_req    <= s_ar;
			st1_border <= (s_ar.x >= param_width) || (s_ar.y >= param_height);
		end
	end

	// ----------------------------------------------------------------------
	// output register, data half lives in the memory read port
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (st1_adv)
			out_valid <= 1'b1;
		else if (s_rready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (st1_adv) begin
			out_user   <= st1_req.user;
			out_border <= st1_border;
		end
	end

	assign s_rvalid   = out_valid;
	assign s_r.user   = out_user;
	assign s_r.data   = out_border ? `TEX_BORDER_DATA : mem_rd;

	assign status.idle   = !st1_valid && !out_valid;
	assign status.stall  = st1_wait || clear_busy;
	assign status.access = lk_first;
	assign status.hit    = lk_first && tag_hit;
	assign status.miss   = lk_first && !tag_hit;

	tex_cache_tag u_tag (
		.clk, .arst_n, .clear_start, .clear_busy,
		.lookup_en, .lookup_index, .lookup_tag, .hit (tag_hit),
		.update_en, .update_index, .update_tag
	);

	tex_cache_mem u_mem (
		.clk, .wr_en, .wr_line, .wr_beat, .wr_data,
		.rd_en     (st1_adv && !st1_border),
		.rd_line   (lookup_index),
		.rd_offset (tex_cache_pkg::texel_offset(st1_req)),
		.rd_data   (mem_rd)
	);

	tex_cache_fill u_fill (
		.clk, .arst_n, .miss_start, .miss_req (st1_req),
		.m_ar, .m_arvalid, .m_arready, .m_r, .m_rvalid,
		.wr_en, .wr_line, .wr_beat, .wr_data,
		.update_en, .update_index, .update_tag, .fill_done
	);

	// response must hold under back-pressure
	a_resp_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		(s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_r))
	);

endmodule

// ==== tex_cache_unit.sv ====
// texture cache unit
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_unit (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              clear_start,
	output logic                              clear_busy,
	input  logic [`TEX_ADDR_X_W-1:0]          param_width,
	input  logic [`TEX_ADDR_Y_W-1:0]          param_height,
	output tex_cache_pkg::cache_status_t      status,
	input  tex_cache_pkg::tex_req_t           s_ar,
	input  logic                              s_arvalid,
	output logic                              s_arready,
	output tex_cache_pkg::tex_resp_t          s_r,
	output logic                              s_rvalid,
	input  logic                              s_rready,
	output tex_cache_pkg::mem_ar_t            m_ar,
	output logic                              m_arvalid,
	input  logic                              m_arready,
	input  tex_cache_pkg::mem_r_t             m_r,
	input  logic                              m_rvalid
);

	// only the basic variant is built
	tex_cache_basic u_tex_cache_basic (
		.clk          (clk),
		.arst_n       (arst_n),
		.clear_start  (clear_start),
		.clear_busy   (clear_busy),
		.param_width  (param_width),
		.param_height (param_height),
		.status       (status),
		.s_ar         (s_ar),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.s_r          (s_r),
		.s_rvalid     (s_rvalid),
		.s_rready     (s_rready),
		.m_ar         (m_ar),
		.m_arvalid    (m_arvalid),
		.m_arready    (m_arready),
		.m_r          (m_r),
		.m_rvalid     (m_rvalid)
	);

endmodule

// ==== tex_mem_model.sv ====
// texture memory responder
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_mem_model (
	input  logic                   clk,
	input  logic                   arst_n,
	input  tex_cache_pkg::mem_ar_t m_ar,
	input  logic                   m_arvalid,
	output logic                   m_arready,
	output tex_cache_pkg::mem_r_t  m_r,
	output logic                   m_rvalid,
	output int                     ar_count
);

	integer                   seed = 32'hea9d;
	tex_cache_pkg::mem_ar_t   blk;
	logic [`TEX_ADDR_X_W-1:0] x;
	logic [`TEX_ADDR_Y_W-1:0] y;

	// ----------------------------------------------------------------------
	// one block at a time: address accept, then 8 beats in row order
	// ----------------------------------------------------------------------
	initial begin
		m_arready = 1'b0;
		m_rvalid  = 1'b0;
		m_r       = '0;
		ar_count  = 0;
		forever begin
			@(posedge clk);
			if (arst_n && m_arvalid) begin
				blk = m_ar;
				repeat ($random(seed) & 3) @(posedge clk);   // address delay
				#1;
				m_arready = 1'b1;
				@(posedge clk);
				#1;
				m_arready = 1'b0;
				ar_count++;
				for (int n = 0; n < 8; n++) begin
					m_rvalid = 1'b0;
					repeat ($random(seed) & 1) begin
						@(posedge clk);
						#1;
					end
					y = {blk.by, 2'(n / 2)};
					x = {blk.bx, 2'(2 * (n % 2))};
					m_r.data[0] = tb_tex_cache.tex_ref(x, y);          // even x in the low half
					m_r.data[1] = tb_tex_cache.tex_ref(x + 1'b1, y);
					m_r.last    = (n == 7);
					m_rvalid    = 1'b1;
					@(posedge clk);
					#1;
				end
				m_rvalid = 1'b0;
				m_r.last = 1'b0;
			end
		end
	end

endmodule

// ==== tb_tex_cache.sv ====
// texture cache testbench
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tb_tex_cache;

	localparam int N_REQ     = 17 + 8 + 6 + 2 + 300;
	localparam int MAX_CYCLE = N_REQ * 40 + 1000;
	localparam int N_RAND    = 300;

	logic                         clk = 1'b0;
	logic                         arst_n;
	logic                         clear_start;
	logic                         clear_busy;
	logic [`TEX_ADDR_X_W-1:0]     param_width;
	logic [`TEX_ADDR_Y_W-1:0]     param_height;
	tex_cache_pkg::cache_status_t status;
	tex_cache_pkg::tex_req_t      s_ar;
	logic                         s_arvalid;
	logic                         s_arready;
	tex_cache_pkg::tex_resp_t     s_r;
	logic                         s_rvalid;
	logic                         s_rready = 1'b1;
	tex_cache_pkg::mem_ar_t       m_ar;
	logic                         m_arvalid;
	logic                         m_arready;
	tex_cache_pkg::mem_r_t        m_r;
	logic                         m_rvalid;
	int                           ar_count;

	integer                   seed = 32'hea9d;
	string                    test_name = "reset";
	logic                     rready_gaps = 1'b0;
	int                       data_errors = 0;
	int                       count_errors = 0;
	int                       other_errors = 0;
	int                       hit_cnt = 0;
	int                       miss_cnt = 0;
	int                       cycles = 0;
	int                       rnd_x [N_RAND];
	int                       rnd_y [N_RAND];
	logic [`TEX_USER_W-1:0]   next_user = '0;
	tex_cache_pkg::tex_resp_t exp_q [$];

	always #2 clk = ~clk;

	tex_cache_unit u_tex_cache_unit (
		.clk, .arst_n, .clear_start, .clear_busy, .param_width, .param_height, .status,
		.s_ar, .s_arvalid, .s_arready, .s_r, .s_rvalid, .s_rready,
		.m_ar, .m_arvalid, .m_arready, .m_r, .m_rvalid
	);

	tex_mem_model u_mem_model (
		.clk, .arst_n, .m_ar, .m_arvalid, .m_arready, .m_r, .m_rvalid, .ar_count
	);

	// y in the upper half, x in the lower half, border outside the texture
	function automatic tex_cache_pkg::texel_t tex_ref(input logic [`TEX_ADDR_X_W-1:0] x,
	                                                 input logic [`TEX_ADDR_Y_W-1:0] y);
		if (x >= param_width || y >= param_height)
			return '0;
		return {12'(y), 12'(x)};
	endfunction

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_resp(input tex_cache_pkg::tex_resp_t want,
	                          input tex_cache_pkg::tex_resp_t got);
		if (got !== want) begin
			data_errors++;
			$display("mismatch %s: expected user %h data %h, actual user %h data %h",
			         test_name, want.user, want.data, got.user, got.data);
		end
	endtask

	task automatic check_status(input tex_cache_pkg::cache_status_t st);
		if ((st.hit && st.miss) || ((st.hit || st.miss) != st.access)) begin
			other_errors++;
			$display("%s: status pulses do not agree, access %b hit %b miss %b",
			         test_name, st.access, st.hit, st.miss);
		end else begin
			hit_cnt  += st.hit;
			miss_cnt += st.miss;
		end
		if ((clear_busy || m_arvalid || m_rvalid) && !st.stall) begin
			other_errors++;
			$display("%s: stall is low while a fill or a clear is in progress", test_name);
		end
		if (st.stall && st.idle && !clear_busy) begin
			other_errors++;
			$display("%s: stall is high with an empty pipeline and no clear", test_name);
		end
		if (st.idle && s_rvalid) begin
			other_errors++;
			$display("%s: idle is high while a response is waiting", test_name);
		end
	endtask

	task automatic check_count(input string what, input int want, input int got);
		if (got != want) begin
			count_errors++;
			$display("mismatch %s %s: expected %0d, actual %0d", test_name, what, want, got);
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------------------
	task automatic read_texel(input int x, input int y);
		tex_cache_pkg::tex_req_t  req;
		tex_cache_pkg::tex_resp_t want;
		req.user  = next_user;
		req.x     = x[`TEX_ADDR_X_W-1:0];
		req.y     = y[`TEX_ADDR_Y_W-1:0];
		want.user = next_user;
		want.data = tex_ref(req.x, req.y);
		next_user = next_user + 1'b1;
		exp_q.push_back(want);
		s_ar      = req;
		s_arvalid = 1'b1;
		do
			@(posedge clk);
		while (!s_arready);
		#1;
		s_arvalid = 1'b0;
	endtask

	task automatic wait_drain();
		do begin
			@(posedge clk);
			#1;
		end while (exp_q.size() != 0 || !status.idle);
	endtask

	always @(posedge clk) begin
		#1;
		if (rready_gaps)
			s_rready = ($random(seed) & 3) != 0;   // roughly one stall in four
		else
			s_rready = 1'b1;
	end

	// response and status monitor
	always @(posedge clk) begin
		if (arst_n) begin
			check_status(status);
			if (s_rvalid && s_rready) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("%s: response arrived with no request outstanding", test_name);
				end else begin
					check_resp(exp_q.pop_front(), s_r);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLE) begin
			$display("timeout after %0d cycles, test %s did not finish", cycles, test_name);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int base_hit;
		int base_miss;
		int base_ar;
		int busy_cycles;
		int in_range;
		arst_n       = 1'b0;
		clear_start  = 1'b0;
		s_ar         = '0;
		s_arvalid    = 1'b0;
		param_width  = 10'd200;
		param_height = 10'd120;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;

		// first read misses, the whole block then hits
		test_name = "block_hit";
		base_hit  = hit_cnt;
		base_miss = miss_cnt;
		base_ar   = ar_count;
		read_texel(8, 12);
		for (int yy = 0; yy < 4; yy++)
			for (int xx = 0; xx < 4; xx++)
				read_texel(8 + xx, 12 + yy);
		wait_drain();
		check_count("hits", 16, hit_cnt - base_hit);
		check_count("misses", 1, miss_cnt - base_miss);
		check_count("memory requests", 1, ar_count - base_ar);

		test_name = "border";
		base_hit  = hit_cnt;
		base_miss = miss_cnt;
		base_ar   = ar_count;
		for (int i = 0; i < 4; i++)
			read_texel(200 + 37 * i, i);
		for (int i = 0; i < 4; i++)
			read_texel(i * 50, 120 + 60 * i);
		wait_drain();
		check_count("lookups", 0, hit_cnt - base_hit + miss_cnt - base_miss);
		check_count("memory requests", 0, ar_count - base_ar);

		// same line index 0, tags differ
		test_name = "evict";
		base_hit  = hit_cnt;
		base_miss = miss_cnt;
		base_ar   = ar_count;
		for (int i = 0; i < 6; i++) begin
			if (i % 2 == 0)
				read_texel(16 + i / 2, 17);
			else
				read_texel(32 + i / 2, 18);
		end
		wait_drain();
		check_count("hits", 0, hit_cnt - base_hit);
		check_count("misses", 6, miss_cnt - base_miss);
		check_count("memory requests", 6, ar_count - base_ar);

		test_name = "clear";
		base_hit  = hit_cnt;
		read_texel(9, 13);
		wait_drain();
		check_count("hits", 1, hit_cnt - base_hit);
		clear_start = 1'b1;
		@(posedge clk);
		#1;
		clear_start = 1'b0;
		busy_cycles = 0;
		do begin
			@(posedge clk);
			if (clear_busy)
				busy_cycles++;
		end while (clear_busy && busy_cycles < 64);
		#1;
		check_count("busy cycles", 16, busy_cycles);
		base_miss = miss_cnt;
		base_ar   = ar_count;
		read_texel(9, 13);
		wait_drain();
		check_count("misses", 1, miss_cnt - base_miss);
		check_count("memory requests", 1, ar_count - base_ar);

		test_name = "random";
		in_range  = 0;
		for (int i = 0; i < N_RAND; i++) begin
			rnd_x[i] = $random(seed) & 32'hff;
			rnd_y[i] = $random(seed) & 32'h7f;
			if (rnd_x[i] < 200 && rnd_y[i] < 120)
				in_range++;
		end
		base_hit    = hit_cnt;
		base_miss   = miss_cnt;
		rready_gaps = 1'b1;
		for (int i = 0; i < N_RAND; i++)
			read_texel(rnd_x[i], rnd_y[i]);
		wait_drain();
		rready_gaps = 1'b0;
		check_count("lookups", in_range, hit_cnt - base_hit + miss_cnt - base_miss);

		$display("errors: %0d data, %0d count, %0d other", data_errors, count_errors,
		         other_errors);
		if (data_errors + count_errors + other_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
tex_cache_pkg.sv
tex_cache_tag.sv
tex_cache_mem.sv
tex_cache_fill.sv
tex_cache_basic.sv
tex_cache_unit.sv
tex_mem_model.sv
tb_tex_cache.sv

// ==== Makefile ====
# texture cache simulation with Verilator

VERILATOR ?= verilator
TOP       ?= tb_tex_cache
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
